/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = spm_tb
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
verilog/spm_pkg.sv
verilog/spm_req_stage.sv
verilog/spsram_wrapper.sv
verilog/spm_rsp_stage.sv
verilog/spm_top.sv
verification/spm_tb.sv

/* verification/spm_input.txt */
// op addr lanes wdata exp_rdata exp_err
// op is decimal, the other columns are hex; a write answers with the merged word
1 00 f 11223344 11223344 0
2 00 0 00000000 11223344 0
3 01 f a5a5a5a5 a5a5a5a5 0
4 01 0 00000000 a5a5a5a5 0
5 48 f cafef00d cafef00d 0
6 48 0 00000000 cafef00d 0
7 c7 f 0badbeef 0badbeef 0
8 c7 0 00000000 0badbeef 0
// partial lane writes merge with stored bytes
9 10 f deadbeef deadbeef 0
10 10 3 00001234 dead1234 0
11 10 0 00000000 dead1234 0
12 10 8 77000000 77ad1234 0
13 10 0 00000000 77ad1234 0
14 20 f 00000000 00000000 0
15 20 4 00ff0000 00ff0000 0
16 20 1 000000ab 00ff00ab 0
17 20 0 00000000 00ff00ab 0
// out of range, memory must stay unchanged
18 c8 f 55555555 00000000 1
19 ff 0 00000000 00000000 1
20 00 0 00000000 11223344 0
21 48 0 00000000 cafef00d 0
22 e0 3 0000ffff 00000000 1
23 c7 0 00000000 0badbeef 0
// back to back traffic
24 30 f 01020304 01020304 0
25 31 f 05060708 05060708 0
26 32 f 090a0b0c 090a0b0c 0
27 33 f 0d0e0f10 0d0e0f10 0
28 30 0 00000000 01020304 0
29 31 0 00000000 05060708 0
30 32 0 00000000 090a0b0c 0
31 33 0 00000000 0d0e0f10 0
32 33 6 00aabb00 0daabb10 0
33 32 9 ee0000dd ee0a0bdd 0
34 33 0 00000000 0daabb10 0
35 32 0 00000000 ee0a0bdd 0
36 01 0 00000000 a5a5a5a5 0
37 10 0 00000000 77ad1234 0
38 20 0 00000000 00ff00ab 0

/* verification/spm_tb.sv */
`timescale 1ns/1ps

module spm_tb import spm_pkg::*; ();

  logic                      clk;
  logic                      rst_n_i;
  logic                      req_valid_i;
  logic [SPM_ADDR_WIDTH-1:0] req_addr_i;
  logic [SPM_LANES-1:0]      req_we_i;
  logic [SPM_DATA_WIDTH-1:0] req_wdata_i;
  logic                      req_credit_o;
  logic                      rsp_valid_o;
  logic [SPM_DATA_WIDTH-1:0] rsp_rdata_o;
  logic                      rsp_err_o;
  logic                      rsp_credit_i;

  // Stimulus and expected responses in file order
  int                        op_q[$];
  logic [SPM_ADDR_WIDTH-1:0] addr_q[$];
  logic [SPM_LANES-1:0]      we_q[$];
  logic [SPM_DATA_WIDTH-1:0] wdata_q[$];
  logic [SPM_DATA_WIDTH-1:0] exp_data_q[$];
  logic                      exp_err_q[$];

  int          num_req   = 0;
  int          sent      = 0;
  int          rsp_count = 0;
  int          credits   = SPM_REQ_CREDITS; // Requester side
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          err_cnt   = 0;
  int          cyc       = 0;
  int          owed      = 0;
  int          due_q[$]; // Cycles when a response credit goes back
  bit          loaded    = 0;
  logic [31:0] lfsr_state = 32'h2975_5f5f;

  spm_top UUT (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_we_i     (req_we_i),
    .req_wdata_i  (req_wdata_i),
    .req_credit_o (req_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .rsp_credit_i (rsp_credit_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic compare_data(input string name, input logic [SPM_DATA_WIDTH-1:0] got,
                              input logic [SPM_DATA_WIDTH-1:0] exp, output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_err(input string name, input logic got, input logic exp,
                             output bit ok);
    ok = (got === exp);
    if (!ok) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Requester model
  initial begin
    @(posedge rst_n_i);
    forever begin
      @(negedge clk);
      if (req_credit_o) begin
        credits++;
      end
      if (credits > 0 && sent < num_req) begin
        req_valid_i = 1'b1;
        req_addr_i  = addr_q[sent];
        req_we_i    = we_q[sent];
        req_wdata_i = wdata_q[sent];
        credits--;
        sent++;
      end else begin
        req_valid_i = 1'b0;
      end
    end
  end

  // Consumer model checks each response in order
  initial begin
    int  delay;
    bit  ok_data;
    bit  ok_err;
    @(posedge rst_n_i);
    forever begin
      @(negedge clk);
      cyc++;
      if (rsp_valid_o) begin
        if (rsp_count >= num_req) begin
          $display("Response received with no request outstanding at %0t", $time);
          err_cnt++;
        end else begin
          compare_data("rsp_rdata_o", rsp_rdata_o, exp_data_q[rsp_count], ok_data);
          compare_err("rsp_err_o", rsp_err_o, exp_err_q[rsp_count], ok_err);
          if (ok_data && ok_err) begin
            pass_cnt++;
            $display("op %0d addr %h: pass", op_q[rsp_count], addr_q[rsp_count]);
          end else begin
            fail_cnt++;
            $display("op %0d addr %h: fail", op_q[rsp_count], addr_q[rsp_count]);
          end
        end
        rsp_count++;
        draw_bits(2, delay); // 0 to 3 cycles
        due_q.push_back(cyc + delay);
      end
      for (int i = due_q.size() - 1; i >= 0; i--) begin
        if (due_q[i] <= cyc) begin
          owed++;
          due_q.delete(i);
        end
      end
      rsp_credit_i = (owed > 0);
      if (owed > 0) begin
        owed--;
      end
    end
  end

  initial begin
    int timeout_cycles;
    wait (loaded);
    timeout_cycles = (num_req > 0 ? num_req : 1) * 40;
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d responses received",
             timeout_cycles, rsp_count, num_req);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    string       line;
    int          fd;
    int          nf;
    int          op;
    logic [31:0] t_addr;
    logic [31:0] t_mask;
    logic [31:0] t_wdata;
    logic [31:0] t_rdata;
    logic [31:0] t_err;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_we_i     = '0;
    req_wdata_i  = '0;
    rsp_credit_i = 1'b0;

    fd = $fopen("verification/spm_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file verification/spm_input.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.substr(0, 1) != "//") begin
          nf = $sscanf(line, "%d %h %h %h %h %h", op, t_addr, t_mask, t_wdata, t_rdata, t_err);
          if (nf == 6) begin
            op_q.push_back(op);
            addr_q.push_back(SPM_ADDR_WIDTH'(t_addr));
            we_q.push_back(SPM_LANES'(t_mask));
            wdata_q.push_back(t_wdata);
            exp_data_q.push_back(t_rdata);
            exp_err_q.push_back(t_err[0]);
          end else begin
            $display("Malformed stimulus line: %s", line);
            err_cnt++;
          end
        end
      end
      $fclose(fd);
    end
    num_req = addr_q.size();
    if (num_req == 0) begin
      $display("No requests found in the stimulus file");
      err_cnt++;
    end
    loaded = 1'b1;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    wait (rsp_count >= num_req);
    repeat (10) @(posedge clk); // Let late credits and stray responses show up

    if (credits != SPM_REQ_CREDITS) begin
      $display("Requester holds %0d credits at the end instead of %0d",
               credits, SPM_REQ_CREDITS);
      err_cnt++;
    end
    if (rsp_count != num_req) begin
      $display("Received %0d responses for %0d requests", rsp_count, num_req);
      err_cnt++;
    end

    $display("Summary: %0d passed, %0d failed, %0d other errors", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog/spm_pkg.sv */
package spm_pkg;

  // Memory geometry
  localparam int unsigned SPM_DATA_WIDTH = 32;
  localparam int unsigned SPM_LANE_SIZE  = 8;
  localparam int unsigned SPM_LANES      = SPM_DATA_WIDTH / SPM_LANE_SIZE;
  localparam int unsigned SPM_DEPTH      = 200; // Not a power of two
  localparam int unsigned SPM_ADDR_WIDTH = 8;
  localparam int unsigned SPM_SRAM_AW    = $clog2(SPM_DEPTH);

  // Flow control
  localparam int unsigned SPM_REQ_CREDITS = 4; // Also request buffer depth
  localparam int unsigned SPM_RSP_CREDITS = 2;
  localparam int unsigned SPM_RSP_DEPTH   = 4;
  localparam int unsigned SPM_CNT_WIDTH   = 3;

  localparam int unsigned SPM_REQ_PTR_WIDTH = $clog2(SPM_REQ_CREDITS);
  localparam int unsigned SPM_RSP_PTR_WIDTH = $clog2(SPM_RSP_DEPTH);

  // Response record is {err, rdata}
  localparam int unsigned SPM_RSP_REC_WIDTH = SPM_DATA_WIDTH + 1;
  localparam int unsigned SPM_RSP_ERR_BIT   = SPM_DATA_WIDTH;

endpackage

/* verilog/spm_req_stage.sv */
`timescale 1ns/1ps

module spm_req_stage import spm_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  input  logic [SPM_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [SPM_LANES-1:0]      req_we_i,
  input  logic [SPM_DATA_WIDTH-1:0] req_wdata_i,
  input  logic                      issue_ready_i,
  output logic                      req_credit_o,
  output logic                      sram_en_o,
  output logic [SPM_ADDR_WIDTH-1:0] sram_addr_o,
  output logic [SPM_LANES-1:0]      sram_we_o,
  output logic [SPM_DATA_WIDTH-1:0] sram_wdata_o,
  output logic                      issue_valid_o,
  output logic                      issue_err_o
);

  logic [SPM_ADDR_WIDTH-1:0]    addr_q  [SPM_REQ_CREDITS];
  logic [SPM_LANES-1:0]         we_q    [SPM_REQ_CREDITS];
  logic [SPM_DATA_WIDTH-1:0]    wdata_q [SPM_REQ_CREDITS];
  logic [SPM_REQ_PTR_WIDTH-1:0] wr_ptr;
  logic [SPM_REQ_PTR_WIDTH-1:0] rd_ptr;
  logic [SPM_CNT_WIDTH-1:0]     count;
  logic                         push;
  logic                         pop;
  logic                         head_err;

  assign push     = req_valid_i; // Requester only sends with a credit
  assign pop      = (count != '0) && issue_ready_i;
  assign head_err = addr_q[rd_ptr] >= SPM_ADDR_WIDTH'(SPM_DEPTH);

  always_ff @(posedge clk) begin
    if (push) begin
      addr_q[wr_ptr]  <= req_addr_i;
      we_q[wr_ptr]    <= req_we_i;
      wdata_q[wr_ptr] <= req_wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at depth 4
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Issue register lines up with the SRAM input
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      req_credit_o  <= 1'b0;
      sram_en_o     <= 1'b0;
      issue_valid_o <= 1'b0;
      issue_err_o   <= 1'b0;
    end else begin
      req_credit_o  <= pop; // Slot freed
      sram_en_o     <= pop && !head_err;
      issue_valid_o <= pop;
      issue_err_o   <= pop && head_err;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      sram_addr_o  <= addr_q[rd_ptr];
      sram_we_o    <= we_q[rd_ptr];
      sram_wdata_o <= wdata_q[rd_ptr];
    end
  end

  // Requester spent a credit it did not have
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    push |-> count < SPM_CNT_WIDTH'(SPM_REQ_CREDITS));

  // Out-of-range request must never touch the SRAM
  a_err_no_en: assert property (@(posedge clk) disable iff (!rst_n_i)
    sram_en_o |-> sram_addr_o < SPM_ADDR_WIDTH'(SPM_DEPTH));

endmodule

/* verilog/spm_rsp_stage.sv */
`timescale 1ns/1ps

module spm_rsp_stage import spm_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      issue_valid_i,
  input  logic                      issue_err_i,
  input  logic [SPM_DATA_WIDTH-1:0] sram_rdata_i,
  input  logic                      rsp_credit_i,
  output logic                      issue_ready_o,
  output logic                      rsp_valid_o,
  output logic [SPM_DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                      rsp_err_o
);

  logic                         align_valid;
  logic                         align_err;
  logic [SPM_RSP_REC_WIDTH-1:0] buf_q [SPM_RSP_DEPTH];
  logic [SPM_RSP_PTR_WIDTH-1:0] wr_ptr;
  logic [SPM_RSP_PTR_WIDTH-1:0] rd_ptr;
  logic [SPM_CNT_WIDTH-1:0]     count;
  logic [SPM_CNT_WIDTH-1:0]     resv_cnt;
  logic [SPM_CNT_WIDTH-1:0]     credit_cnt;
  logic [SPM_DATA_WIDTH-1:0]    push_data;
  logic [SPM_RSP_REC_WIDTH-1:0] head_rec;
  logic                         push;
  logic                         pop;

  assign push      = align_valid;
  assign push_data = align_err ? '0 : sram_rdata_i; // Errored requests carry zero
  assign pop       = (count != '0) && (credit_cnt != '0);
  assign head_rec  = buf_q[rd_ptr];

  // Issue in flight still needs a slot
  assign issue_ready_o = (resv_cnt + SPM_CNT_WIDTH'(issue_valid_i))
                         < SPM_CNT_WIDTH'(SPM_RSP_DEPTH);

  assign rsp_valid_o = pop;
  assign rsp_rdata_o = head_rec[SPM_DATA_WIDTH-1:0];
  assign rsp_err_o   = head_rec[SPM_RSP_ERR_BIT];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      align_valid <= 1'b0;
      align_err   <= 1'b0;
    end else begin
      align_valid <= issue_valid_i; // Matches SRAM read latency
      align_err   <= issue_err_i;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      buf_q[wr_ptr] <= {align_err, push_data};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Covers the alignment register plus buffered entries
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      resv_cnt <= '0;
    end else begin
      case ({issue_valid_i, pop})
        2'b10:   resv_cnt <= resv_cnt + 1'b1;
        2'b01:   resv_cnt <= resv_cnt - 1'b1;
        default: resv_cnt <= resv_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      credit_cnt <= SPM_CNT_WIDTH'(SPM_RSP_CREDITS);
    end else begin
      case ({rsp_credit_i, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Consumer returned more than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
    credit_cnt <= SPM_CNT_WIDTH'(SPM_RSP_CREDITS));

  // Reservation must keep the buffer from overflowing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    push |-> count < SPM_CNT_WIDTH'(SPM_RSP_DEPTH));

endmodule

/* verilog/spm_top.sv */
`timescale 1ns/1ps

module spm_top import spm_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  input  logic [SPM_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [SPM_LANES-1:0]      req_we_i,
  input  logic [SPM_DATA_WIDTH-1:0] req_wdata_i,
  output logic                      req_credit_o,
  output logic                      rsp_valid_o,
  output logic [SPM_DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                      rsp_err_o,
  input  logic                      rsp_credit_i
);

  logic                      sram_en;
  logic [SPM_ADDR_WIDTH-1:0] sram_addr;
  logic [SPM_LANES-1:0]      sram_we;
  logic [SPM_DATA_WIDTH-1:0] sram_wdata;
  logic [SPM_DATA_WIDTH-1:0] sram_rdata;
  logic                      issue_valid;
  logic                      issue_err;
  logic                      issue_ready;

  spm_req_stage u_req_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_we_i      (req_we_i),
    .req_wdata_i   (req_wdata_i),
    .issue_ready_i (issue_ready),
    .req_credit_o  (req_credit_o),
    .sram_en_o     (sram_en),
    .sram_addr_o   (sram_addr),
    .sram_we_o     (sram_we),
    .sram_wdata_o  (sram_wdata),
    .issue_valid_o (issue_valid),
    .issue_err_o   (issue_err)
  );

  spsram_wrapper u_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .addr_i  (sram_addr),
    .en_i    (sram_en),
    .we_i    (sram_we),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  spm_rsp_stage u_rsp_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid),
    .issue_err_i   (issue_err),
    .sram_rdata_i  (sram_rdata),
    .rsp_credit_i  (rsp_credit_i),
    .issue_ready_o (issue_ready),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_err_o     (rsp_err_o)
  );

endmodule

/* verilog/spsram_wrapper.sv */
`timescale 1ns/1ps

module spsram_wrapper import spm_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [SPM_ADDR_WIDTH-1:0] addr_i,
  input  logic                      en_i,
  input  logic [SPM_LANES-1:0]      we_i,
  input  logic [SPM_DATA_WIDTH-1:0] wdata_i,
  output logic [SPM_DATA_WIDTH-1:0] rdata_o
);

  logic [SPM_LANES-1:0][SPM_LANE_SIZE-1:0] mem [SPM_DEPTH];
  logic [SPM_LANES-1:0][SPM_LANE_SIZE-1:0] wdata_lanes;
  logic [SPM_LANES-1:0][SPM_LANE_SIZE-1:0] rdata_q;
  logic [SPM_SRAM_AW-1:0]                  word_addr;

  assign wdata_lanes = wdata_i;
  assign word_addr   = addr_i[SPM_SRAM_AW-1:0]; // Only bits needed for the depth
  assign rdata_o     = rdata_q;

  always_ff @(posedge clk) begin
    if (en_i) begin
      for (int i = 0; i < SPM_LANES; i++) begin
        if (we_i[i]) begin
          mem[word_addr][i] <= wdata_lanes[i];
        end
      end
    end
  end

  // Written lanes bypass the array for write-first
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (en_i) begin
      for (int i = 0; i < SPM_LANES; i++) begin
        if (we_i[i]) begin
          rdata_q[i] <= wdata_lanes[i];
        end else begin
          rdata_q[i] <= mem[word_addr][i];
        end
      end
    end
  end

endmodule
